// ==== compile.f ====
+incdir+tests
design/frame_pkg.sv
design/frame_len_check.sv
design/frame_fifo.sv
design/frame_egress.sv
design/frame_pipe_top.sv
tests/frame_pipe_tb.sv

// ==== design/frame_egress.sv ====
`timescale 1ns/1ps

module frame_egress (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [frame_pkg::data_width-1:0]  fifo_data,
  input  logic                             fifo_last,
  input  logic                             fifo_valid,
  output logic                             fifo_ready,
  output logic [frame_pkg::data_width-1:0]  out_data,
  output logic                             out_last,
  output logic                             out_valid,
  input  logic                             out_ready,
  output logic [frame_pkg::count_width-1:0] frame_count,
  output logic [frame_pkg::count_width-1:0] byte_count
);

  logic xfer;

  // no buffering here, the stream goes out as it comes in
  assign out_data   = fifo_data;
  assign out_last   = fifo_last;
  assign out_valid  = fifo_valid;
  assign fifo_ready = out_ready;

  assign xfer = fifo_valid && out_ready;

  // both counters are free running and wrap
  always_ff @(posedge clk) begin
    if (rst) begin
      frame_count <= '0;
      byte_count  <= '0;
    end else if (xfer) begin
      byte_count <= byte_count + 1'b1;
      if (fifo_last) begin
        frame_count <= frame_count + 1'b1;
      end
    end
  end

endmodule

// ==== design/frame_fifo.sv ====
`timescale 1ns/1ps

module frame_fifo (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [frame_pkg::data_width-1:0] chk_data,
  input  logic                            chk_last,
  input  logic                            chk_bad,
  input  logic                            chk_valid,
  output logic                            chk_ready,
  output logic [frame_pkg::data_width-1:0] fifo_data,
  output logic                            fifo_last,
  output logic                            fifo_valid,
  input  logic                            fifo_ready,
  output logic                            status_good_frame,
  output logic                            status_bad_frame,
  output logic                            status_overflow
);

  localparam int aw = frame_pkg::addr_width;
  localparam int dw = frame_pkg::data_width;

  // each word holds the data byte with last on top
  logic [dw:0] mem [frame_pkg::fifo_depth];

  // wr_ptr marks the end of committed frames, wr_ptr_cur the frame being written
  logic [aw:0] wr_ptr;
  logic [aw:0] wr_ptr_next;
  logic [aw:0] wr_ptr_cur;
  logic [aw:0] wr_ptr_cur_next;
  logic [aw:0] rd_ptr;
  logic [aw:0] rd_ptr_next;

  logic        full_cur;
  logic        full_wr;
  logic        empty;
  logic        write;
  logic        read;
  logic        store_output;

  logic        drop_frame;
  logic        drop_frame_next;
  logic        good_next;
  logic        bad_next;
  logic        overflow_next;

  // read pipeline, memory read register then output register
  logic [dw:0] rd_data;
  logic        rd_data_valid;
  logic        rd_data_valid_next;
  logic [dw:0] out_reg;
  logic        out_valid;
  logic        out_valid_next;

  assign full_cur = (wr_ptr_cur[aw] != rd_ptr[aw]) &&
                    (wr_ptr_cur[aw-1:0] == rd_ptr[aw-1:0]);
  // the frame in progress alone has filled the whole buffer
  assign full_wr  = (wr_ptr_cur[aw] != wr_ptr[aw]) &&
                    (wr_ptr_cur[aw-1:0] == wr_ptr[aw-1:0]);
  assign empty    = wr_ptr == rd_ptr;

  // an oversized frame keeps flowing so that it can be thrown away
  assign chk_ready = !full_cur || full_wr;

  always_comb begin
    write           = 1'b0;
    drop_frame_next = drop_frame;
    good_next       = 1'b0;
    bad_next        = 1'b0;
    overflow_next   = 1'b0;
    wr_ptr_next     = wr_ptr;
    wr_ptr_cur_next = wr_ptr_cur;
    if (chk_valid && chk_ready) begin
      if (full_cur || full_wr || drop_frame) begin
        drop_frame_next = 1'b1;
        if (chk_last) begin
          wr_ptr_cur_next = wr_ptr;
          drop_frame_next = 1'b0;
          overflow_next   = 1'b1;
        end
      end else begin
        write           = 1'b1;
        wr_ptr_cur_next = wr_ptr_cur + 1'b1;
        if (chk_last) begin
          if (chk_bad) begin
            wr_ptr_cur_next = wr_ptr;
            bad_next        = 1'b1;
          end else begin
            wr_ptr_next = wr_ptr_cur + 1'b1;
            good_next   = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr            <= '0;
      wr_ptr_cur        <= '0;
      drop_frame        <= 1'b0;
      status_good_frame <= 1'b0;
      status_bad_frame  <= 1'b0;
      status_overflow   <= 1'b0;
    end else begin
      wr_ptr            <= wr_ptr_next;
      wr_ptr_cur        <= wr_ptr_cur_next;
      drop_frame        <= drop_frame_next;
      status_good_frame <= good_next;
      status_bad_frame  <= bad_next;
      status_overflow   <= overflow_next;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_ptr_cur[aw-1:0]] <= {chk_last, chk_data};
    end
  end

  // fetch a new word whenever the read register is free or moves on
  always_comb begin
    read               = 1'b0;
    rd_ptr_next        = rd_ptr;
    rd_data_valid_next = rd_data_valid;
    if (store_output || !rd_data_valid) begin
      if (!empty) begin
        read               = 1'b1;
        rd_data_valid_next = 1'b1;
        rd_ptr_next        = rd_ptr + 1'b1;
      end else begin
        rd_data_valid_next = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr        <= '0;
      rd_data_valid <= 1'b0;
    end else begin
      rd_ptr        <= rd_ptr_next;
      rd_data_valid <= rd_data_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      rd_data <= mem[rd_ptr[aw-1:0]];
    end
  end

  // output register loads when empty or when its word is taken
  always_comb begin
    store_output   = 1'b0;
    out_valid_next = out_valid;
    if (fifo_ready || !out_valid) begin
      store_output   = 1'b1;
      out_valid_next = rd_data_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= out_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (store_output) begin
      out_reg <= rd_data;
    end
  end

  assign fifo_valid = out_valid;
  assign fifo_data  = out_reg[dw-1:0];
  assign fifo_last  = out_reg[dw];

endmodule

// ==== design/frame_len_check.sv ====
`timescale 1ns/1ps

module frame_len_check (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [frame_pkg::data_width-1:0] in_data,
  input  logic                            in_last,
  input  logic                            in_error,
  input  logic                            in_valid,
  output logic                            in_ready,
  output logic [frame_pkg::data_width-1:0] chk_data,
  output logic                            chk_last,
  output logic                            chk_bad,
  output logic                            chk_valid,
  input  logic                            chk_ready
);

  // beats already transferred in the current frame
  logic [frame_pkg::len_width-1:0] beat_cnt;
  // length of the frame including the beat on the input now
  logic [frame_pkg::len_width-1:0] cur_len;
  logic                            err_seen;
  logic                            xfer;
  logic                            too_short;
  logic                            too_long;

  // the stream itself passes straight through
  assign chk_data  = in_data;
  assign chk_last  = in_last;
  assign chk_valid = in_valid;
  assign in_ready  = chk_ready;

  assign xfer = in_valid && chk_ready;

  always_comb begin
    if (&beat_cnt) begin
      cur_len = beat_cnt;
    end else begin
      cur_len = beat_cnt + 1'b1;
    end
  end

  assign too_short = cur_len < frame_pkg::min_frame_len;
  assign too_long  = cur_len > frame_pkg::max_frame_len;

  // only looked at downstream while chk_last is high
  assign chk_bad = too_short || too_long || err_seen || in_error;

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt <= '0;
      err_seen <= 1'b0;
    end else if (xfer) begin
      if (in_last) begin
        beat_cnt <= '0;
        err_seen <= 1'b0;
      end else begin
        beat_cnt <= cur_len;
        err_seen <= err_seen || in_error;
      end
    end
  end

endmodule

// ==== design/frame_pipe_top.sv ====
`timescale 1ns/1ps

module frame_pipe_top (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [frame_pkg::data_width-1:0]  in_data,
  input  logic                             in_last,
  input  logic                             in_error,
  input  logic                             in_valid,
  output logic                             in_ready,
  output logic [frame_pkg::data_width-1:0]  out_data,
  output logic                             out_last,
  output logic                             out_valid,
  input  logic                             out_ready,
  output logic                             status_good_frame,
  output logic                             status_bad_frame,
  output logic                             status_overflow,
  output logic [frame_pkg::count_width-1:0] frame_count,
  output logic [frame_pkg::count_width-1:0] byte_count
);

  // checker to FIFO
  logic [frame_pkg::data_width-1:0] chk_data;
  logic                            chk_last;
  logic                            chk_bad;
  logic                            chk_valid;
  logic                            chk_ready;

  // FIFO to egress
  logic [frame_pkg::data_width-1:0] fifo_data;
  logic                            fifo_last;
  logic                            fifo_valid;
  logic                            fifo_ready;

  frame_len_check len_check0 (
    .clk       (clk),
    .rst       (rst),
    .in_data   (in_data),
    .in_last   (in_last),
    .in_error  (in_error),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .chk_data  (chk_data),
    .chk_last  (chk_last),
    .chk_bad   (chk_bad),
    .chk_valid (chk_valid),
    .chk_ready (chk_ready)
  );

  frame_fifo fifo0 (
    .clk               (clk),
    .rst               (rst),
    .chk_data          (chk_data),
    .chk_last          (chk_last),
    .chk_bad           (chk_bad),
    .chk_valid         (chk_valid),
    .chk_ready         (chk_ready),
    .fifo_data         (fifo_data),
    .fifo_last         (fifo_last),
    .fifo_valid        (fifo_valid),
    .fifo_ready        (fifo_ready),
    .status_good_frame (status_good_frame),
    .status_bad_frame  (status_bad_frame),
    .status_overflow   (status_overflow)
  );

  frame_egress egress0 (
    .clk         (clk),
    .rst         (rst),
    .fifo_data   (fifo_data),
    .fifo_last   (fifo_last),
    .fifo_valid  (fifo_valid),
    .fifo_ready  (fifo_ready),
    .out_data    (out_data),
    .out_last    (out_last),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .frame_count (frame_count),
    .byte_count  (byte_count)
  );

endmodule

// ==== design/frame_pkg.sv ====
package frame_pkg;

  // width of one stream beat
  localparam int data_width = 8;

  // FIFO storage, pointers carry one extra wrap bit
  localparam int addr_width = 6;
  localparam int fifo_depth = 64;

  // beat counter in the checker saturates at its all-ones value
  localparam int len_width = 7;

  // frame length limits for a good frame, in beats
  localparam logic [len_width-1:0] min_frame_len = 7'd2;
  localparam logic [len_width-1:0] max_frame_len = 7'd48;

  // delivered frame and byte counters at the egress
  localparam int count_width = 16;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the frame pipe testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module frame_pipe_tb -o frame_pipe_sim

# the verdict comes from the log, not from the exit status
./obj_dir/frame_pipe_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation PASSED$" sim.log; then
  echo "run_sim: testbench reported success"
  exit 0
else
  echo "run_sim: testbench did not report success"
  exit 1
fi

// ==== tests/frame_pipe_model.svh ====
`ifndef FRAME_PIPE_MODEL_SVH
`define FRAME_PIPE_MODEL_SVH

localparam int kind_good     = 0;
localparam int kind_bad      = 1;
localparam int kind_overflow = 2;

// bytes and error flags of the frame being generated
logic [frame_pkg::data_width-1:0] frame_buf [128];
logic                             frame_err [128];

// expected output words with the last flag above the data byte
logic [frame_pkg::data_width:0] exp_q [$];

int good_frames     = 0;
int bad_frames      = 0;
int overflow_frames = 0;

logic [frame_pkg::count_width-1:0] exp_frame_count = '0;
logic [frame_pkg::count_width-1:0] exp_byte_count  = '0;

// a frame that cannot fit the buffer is lost before its length is judged
function automatic int classify_frame(input int len, input bit has_err);
  int kind;
  if (len > frame_pkg::fifo_depth) begin
    kind = kind_overflow;
  end else if (len < int'(frame_pkg::min_frame_len) || len > int'(frame_pkg::max_frame_len) ||
               has_err) begin
    kind = kind_bad;
  end else begin
    kind = kind_good;
  end
  return kind;
endfunction

task automatic record_frame(input int len);
  bit   has_err;
  int   kind;
  int   i;
  logic last_bit;
  has_err = 1'b0;
  for (i = 0; i < len; i++) begin
    has_err = has_err | frame_err[i];
  end
  kind = classify_frame(len, has_err);
  if (kind == kind_overflow) begin
    overflow_frames++;
  end else if (kind == kind_bad) begin
    bad_frames++;
  end else begin
    good_frames++;
    exp_frame_count = exp_frame_count + 1'b1;
    for (i = 0; i < len; i++) begin
      last_bit = (i == len - 1);
      exp_q.push_back({last_bit, frame_buf[i]});
      exp_byte_count = exp_byte_count + 1'b1;
    end
  end
endtask

`endif

// ==== tests/frame_pipe_tb.sv ====
`timescale 1ns/1ps

module frame_pipe_tb;

  localparam int num_frames   = 200;
  localparam int max_gen_len  = 72;
  localparam int clk_period   = 4;
  localparam int stall_frame  = 100;
  localparam int stall_cycles = 400;
  // every frame at full length with four cycles per beat, plus the long stall
  localparam int timeout_ns   = num_frames * max_gen_len * 4 * clk_period +
                                stall_cycles * clk_period;

  logic                              clk;
  logic                              rst;
  logic [frame_pkg::data_width-1:0]  in_data;
  logic                              in_last;
  logic                              in_error;
  logic                              in_valid;
  logic                              in_ready;
  logic [frame_pkg::data_width-1:0]  out_data;
  logic                              out_last;
  logic                              out_valid;
  logic                              out_ready;
  logic                              status_good_frame;
  logic                              status_bad_frame;
  logic                              status_overflow;
  logic [frame_pkg::count_width-1:0] frame_count;
  logic [frame_pkg::count_width-1:0] byte_count;

  integer      seed;
  logic [31:0] rnd;
  logic [31:0] rnd_ready;
  logic        ready_next;
  bit          stall_req = 1'b0;
  int          stall_cnt = 0;

  // monitor state
  int                             seen_good     = 0;
  int                             seen_bad      = 0;
  int                             seen_overflow = 0;
  int                             stall_run     = 0;
  int                             longest_stall = 0;
  bit                             hold_pending  = 1'b0;
  logic [frame_pkg::data_width:0] held_word;
  logic [frame_pkg::data_width:0] exp_word;

  `include "frame_pipe_model.svh"

  frame_pipe_top dut0 (
    .clk               (clk),
    .rst               (rst),
    .in_data           (in_data),
    .in_last           (in_last),
    .in_error          (in_error),
    .in_valid          (in_valid),
    .in_ready          (in_ready),
    .out_data          (out_data),
    .out_last          (out_last),
    .out_valid         (out_valid),
    .out_ready         (out_ready),
    .status_good_frame (status_good_frame),
    .status_bad_frame  (status_bad_frame),
    .status_overflow   (status_overflow),
    .frame_count       (frame_count),
    .byte_count        (byte_count)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  task automatic build_frame(output int len);
    int i;
    rnd = $random(seed);
    len = 1 + int'(rnd % max_gen_len);
    for (i = 0; i < len; i++) begin
      rnd = $random(seed);
      frame_buf[i] = rnd[frame_pkg::data_width-1:0];
      rnd = $random(seed);
      // roughly one beat in sixty carries the error flag
      frame_err[i] = (rnd % 32'd60) == 32'd0;
    end
  endtask

  // in_ready only moves on a clock edge, so the mid-cycle value decides the transfer
  task automatic wait_accept;
    bit done;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = in_ready;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send_frame(input int len);
    int i;
    for (i = 0; i < len; i++) begin
      in_valid = 1'b1;
      in_data  = frame_buf[i];
      in_error = frame_err[i];
      in_last  = (i == len - 1);
      wait_accept();
    end
    in_valid = 1'b0;
    in_last  = 1'b0;
    in_error = 1'b0;
  endtask

  // out_ready is random, held low for a long stretch once the stall is requested
  // the next value is picked at the falling edge and driven just after the rising edge
  initial begin
    out_ready = 1'b0;
    forever begin
      @(negedge clk);
      rnd_ready = $random(seed);
      if (rst) begin
        ready_next = 1'b0;
      end else if (stall_req && stall_cnt < stall_cycles) begin
        ready_next = 1'b0;
        stall_cnt++;
      end else begin
        ready_next = rnd_ready[1:0] != 2'b00;
      end
      @(posedge clk);
      #1;
      out_ready = ready_next;
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      if (hold_pending) begin
        assert (out_valid) else begin
          $display("out_valid dropped while a beat was held under back-pressure");
          $display("Simulation FAILED");
          $fatal(1);
        end
        assert ({out_last, out_data} == held_word) else begin
          $display("error: out_data/out_last = 0x%h, held value 0x%h",
                   {out_last, out_data}, held_word);
          $display("Simulation FAILED");
          $fatal(1);
        end
      end
      if (out_valid && out_ready) begin
        assert (exp_q.size() > 0) else begin
          $display("output beat 0x%h arrived with no expected byte left", out_data);
          $display("Simulation FAILED");
          $fatal(1);
        end
        exp_word = exp_q.pop_front();
        assert (out_data == exp_word[frame_pkg::data_width-1:0]) else begin
          $display("error: out_data = 0x%h, expected 0x%h",
                   out_data, exp_word[frame_pkg::data_width-1:0]);
          $display("Simulation FAILED");
          $fatal(1);
        end
        assert (out_last == exp_word[frame_pkg::data_width]) else begin
          $display("error: out_last = 0x%h, expected 0x%h",
                   out_last, exp_word[frame_pkg::data_width]);
          $display("Simulation FAILED");
          $fatal(1);
        end
      end
      hold_pending = out_valid && !out_ready;
      held_word    = {out_last, out_data};
      if (out_valid && !out_ready) begin
        stall_run++;
      end else begin
        stall_run = 0;
      end
      if (stall_run > longest_stall) begin
        longest_stall = stall_run;
      end
      if (status_good_frame) begin
        seen_good++;
      end
      if (status_bad_frame) begin
        seen_bad++;
      end
      if (status_overflow) begin
        seen_overflow++;
      end
    end
  end

  initial begin
    #(timeout_ns);
    $display("watchdog expired after %0d ns before all frames were delivered", timeout_ns);
    $display("Simulation FAILED");
    $fatal(1);
  end

  initial begin
    int len;
    int f;
    int gap;
    seed     = 32'h28b0_3cba;
    rst      = 1'b1;
    in_data  = '0;
    in_last  = 1'b0;
    in_error = 1'b0;
    in_valid = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // nothing may come out of a freshly reset pipe
    repeat (3) begin
      @(negedge clk);
      assert (!out_valid && !status_good_frame && !status_bad_frame && !status_overflow)
      else begin
        $display("output valid or a status pulse was high right after reset");
        $display("Simulation FAILED");
        $fatal(1);
      end
      assert (frame_count == '0 && byte_count == '0) else begin
        $display("error: frame_count = 0x%h, byte_count = 0x%h after reset, expected 0x0",
                 frame_count, byte_count);
        $display("Simulation FAILED");
        $fatal(1);
      end
    end
    @(posedge clk);
    #1;

    for (f = 0; f < num_frames; f++) begin
      if (f == stall_frame) begin
        stall_req = 1'b1;
      end
      build_frame(len);
      record_frame(len);
      send_frame(len);
      rnd = $random(seed);
      gap = int'(rnd % 32'd5);
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end

    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    // let the last transfer and its counter update settle
    repeat (2) @(negedge clk);

    assert (!out_valid) else begin
      $display("out_valid is still high after every expected byte was delivered");
      $display("Simulation FAILED");
      $fatal(1);
    end
    assert (seen_good == good_frames) else begin
      $display("error: status_good_frame pulses = 0x%h, expected 0x%h", seen_good, good_frames);
      $display("Simulation FAILED");
      $fatal(1);
    end
    assert (seen_bad == bad_frames) else begin
      $display("error: status_bad_frame pulses = 0x%h, expected 0x%h", seen_bad, bad_frames);
      $display("Simulation FAILED");
      $fatal(1);
    end
    assert (seen_overflow == overflow_frames) else begin
      $display("error: status_overflow pulses = 0x%h, expected 0x%h",
               seen_overflow, overflow_frames);
      $display("Simulation FAILED");
      $fatal(1);
    end
    assert (frame_count == exp_frame_count) else begin
      $display("error: frame_count = 0x%h, expected 0x%h", frame_count, exp_frame_count);
      $display("Simulation FAILED");
      $fatal(1);
    end
    assert (byte_count == exp_byte_count) else begin
      $display("error: byte_count = 0x%h, expected 0x%h", byte_count, exp_byte_count);
      $display("Simulation FAILED");
      $fatal(1);
    end
    assert (longest_stall >= stall_cycles / 2) else begin
      $display("the output was never held under back-pressure for a long stretch");
      $display("Simulation FAILED");
      $fatal(1);
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule
